// File: design/ray_defines.svh
`ifndef RAY_DEFINES_SVH
`define RAY_DEFINES_SVH

// field widths
`define RAY_COORD_W     16
`define RAY_PIX_X_W     11
`define RAY_PIX_Y_W     10
`define RAY_DIR_W       18
`define RAY_UNIT_FRAC   14

// camera register map
`define RAY_ADDR_W      3
`define RAY_REG_EYE_X   3'd0
`define RAY_REG_EYE_Y   3'd1
`define RAY_REG_EYE_Z   3'd2
`define RAY_REG_ORG_X   3'd3
`define RAY_REG_ORG_Y   3'd4
`define RAY_REG_PLANE_Z 3'd5
`define RAY_REG_WIDTH   3'd6
`define RAY_REG_HEIGHT  3'd7

// squares plus root plus three divides plus output stage
`define RAY_NORM_CYCLES 118

`endif

// File: design/ray_pkg.sv
`include "ray_defines.svh"

package ray_pkg;

    ////////////////////////////////////////
    // world and screen space

    // signed world coordinate
    typedef logic signed [`RAY_COORD_W-1:0] coord_t;

    typedef logic [`RAY_PIX_X_W-1:0] pix_x_t;
    typedef logic [`RAY_PIX_Y_W-1:0] pix_y_t;

    ////////////////////////////////////////
    // direction math

    // plane point minus eye, before normalizing
    typedef logic signed [`RAY_DIR_W-1:0] dir_t;

    // three squared components, with headroom
    typedef logic [2*`RAY_DIR_W+3:0] len_sq_t;

    // floor of the square root of len_sq_t
    typedef logic [`RAY_DIR_W+1:0] len_t;

    // Q1.14 unit component
    typedef logic signed [`RAY_UNIT_FRAC+1:0] unit_t;

    // register write data
    typedef logic [`RAY_COORD_W-1:0] cfg_data_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_ISSUE,
        SCAN_WAIT,
        SCAN_DONE
    } scan_state_t;

endpackage

// File: design/camera_regs.sv
`timescale 1ns/100ps
`include "ray_defines.svh"

module camera_regs (
    input  logic                    clk_in,
    input  logic                    rst_n,

    input  logic                    cfg_we,
    input  logic [`RAY_ADDR_W-1:0]  cfg_addr,
    input  ray_pkg::cfg_data_t      cfg_wdata,

    output ray_pkg::coord_t         eye_x,
    output ray_pkg::coord_t         eye_y,
    output ray_pkg::coord_t         eye_z,
    output ray_pkg::coord_t         org_x,
    output ray_pkg::coord_t         org_y,
    output ray_pkg::coord_t         plane_z,
    output ray_pkg::pix_x_t         win_w,
    output ray_pkg::pix_y_t         win_h
);

    // one register per address, written on the strobe
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            eye_x   <= '0;
            eye_y   <= '0;
            eye_z   <= '0;
            org_x   <= '0;
            org_y   <= '0;
            plane_z <= '0;
            win_w   <= '0;
            win_h   <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                `RAY_REG_EYE_X: begin
                    eye_x <= ray_pkg::coord_t'(cfg_wdata);
                end
                `RAY_REG_EYE_Y: begin
                    eye_y <= ray_pkg::coord_t'(cfg_wdata);
                end
                `RAY_REG_EYE_Z: begin
                    eye_z <= ray_pkg::coord_t'(cfg_wdata);
                end
                `RAY_REG_ORG_X: begin
                    org_x <= ray_pkg::coord_t'(cfg_wdata);
                end
                `RAY_REG_ORG_Y: begin
                    org_y <= ray_pkg::coord_t'(cfg_wdata);
                end
                `RAY_REG_PLANE_Z: begin
                    plane_z <= ray_pkg::coord_t'(cfg_wdata);
                end
                // window size keeps only the low bits
                `RAY_REG_WIDTH: begin
                    win_w <= cfg_wdata[`RAY_PIX_X_W-1:0];
                end
                `RAY_REG_HEIGHT: begin
                    win_h <= cfg_wdata[`RAY_PIX_Y_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: design/pixel_scan.sv
`timescale 1ns/100ps

module pixel_scan (
    input  logic              clk_in,
    input  logic              rst_n,

    input  logic              frame_start,
    input  ray_pkg::pix_x_t   win_w,
    input  ray_pkg::pix_y_t   win_h,
    input  logic              res_valid,

    output logic              pix_valid,
    output ray_pkg::pix_x_t   pix_x,
    output ray_pkg::pix_y_t   pix_y,
    output logic              frame_done
);

    ray_pkg::scan_state_t state;

    logic empty_win;
    logic last_col;
    logic last_row;

    assign empty_win = (win_w == '0) || (win_h == '0);
    assign last_col  = (pix_x == win_w - ray_pkg::pix_x_t'(1));
    assign last_row  = (pix_y == win_h - ray_pkg::pix_y_t'(1));

    // row-major walk, one pixel in flight
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state <= ray_pkg::SCAN_IDLE;
            pix_x <= '0;
            pix_y <= '0;
        end else begin
            case (state)
                ray_pkg::SCAN_IDLE: begin
                    if (frame_start) begin
                        pix_x <= '0;
                        pix_y <= '0;
                        state <= empty_win ? ray_pkg::SCAN_DONE : ray_pkg::SCAN_ISSUE;
                    end
                end
                ray_pkg::SCAN_ISSUE: begin
                    state <= ray_pkg::SCAN_WAIT;
                end
                ray_pkg::SCAN_WAIT: begin
                    if (res_valid) begin
                        if (last_col && last_row) begin
                            state <= ray_pkg::SCAN_DONE;
                        end else begin
                            state <= ray_pkg::SCAN_ISSUE;
                            if (last_col) begin
                                pix_x <= '0;
                                pix_y <= pix_y + ray_pkg::pix_y_t'(1);
                            end else begin
                                pix_x <= pix_x + ray_pkg::pix_x_t'(1);
                            end
                        end
                    end
                end
                default: begin
                    state <= ray_pkg::SCAN_IDLE;
                end
            endcase
        end
    end

    assign pix_valid  = (state == ray_pkg::SCAN_ISSUE);
    assign frame_done = (state == ray_pkg::SCAN_DONE);

endmodule

// File: design/eye_to_pixel.sv
`timescale 1ns/100ps

module eye_to_pixel (
    input  logic             clk_in,
    input  logic             rst_n,

    input  logic             pix_valid,
    input  ray_pkg::pix_x_t  pix_x,
    input  ray_pkg::pix_y_t  pix_y,

    input  ray_pkg::coord_t  eye_x,
    input  ray_pkg::coord_t  eye_y,
    input  ray_pkg::coord_t  eye_z,
    input  ray_pkg::coord_t  org_x,
    input  ray_pkg::coord_t  org_y,
    input  ray_pkg::coord_t  plane_z,

    output logic             dir_in_valid,
    output ray_pkg::dir_t    dx,
    output ray_pkg::dir_t    dy,
    output ray_pkg::dir_t    dz
);

    ////////////////////////////////////////
    // stage one, point on the plane

    logic          pt_valid;
    ray_pkg::dir_t pt_x;
    ray_pkg::dir_t pt_y;
    ray_pkg::dir_t pt_z;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pt_valid <= 1'b0;
        end else begin
            pt_valid <= pix_valid;
        end
    end

    // plane axes are the world x and y axes
    always_ff @(posedge clk_in) begin
        if (pix_valid) begin
            pt_x <= ray_pkg::dir_t'(org_x) + ray_pkg::dir_t'(pix_x);
            pt_y <= ray_pkg::dir_t'(org_y) + ray_pkg::dir_t'(pix_y);
            pt_z <= ray_pkg::dir_t'(plane_z);
        end
    end

    ////////////////////////////////////////
    // stage two, point minus eye

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            dir_in_valid <= 1'b0;
        end else begin
            dir_in_valid <= pt_valid;
        end
    end

    // 18 bits hold the widest difference of two 16-bit values plus x
    always_ff @(posedge clk_in) begin
        if (pt_valid) begin
            dx <= pt_x - ray_pkg::dir_t'(eye_x);
            dy <= pt_y - ray_pkg::dir_t'(eye_y);
            dz <= pt_z - ray_pkg::dir_t'(eye_z);
        end
    end

endmodule

// File: design/vec_normalize.sv
`timescale 1ns/100ps
`include "ray_defines.svh"

module vec_normalize (
    input  logic            clk_in,
    input  logic            rst_n,

    input  logic            dir_in_valid,
    input  ray_pkg::dir_t   dx,
    input  ray_pkg::dir_t   dy,
    input  ray_pkg::dir_t   dz,

    output logic            res_valid,
    output ray_pkg::unit_t  ux,
    output ray_pkg::unit_t  uy,
    output ray_pkg::unit_t  uz
);

    localparam int SQ_W   = $bits(ray_pkg::len_sq_t);
    localparam int LEN_W  = $bits(ray_pkg::len_t);
    localparam int UNIT_W = $bits(ray_pkg::unit_t);
    localparam int DVD_W  = `RAY_DIR_W + `RAY_UNIT_FRAC;
    localparam int RT_W   = LEN_W + 3;
    localparam int CNT_W  = $clog2(DVD_W);

    typedef enum logic [1:0] {
        NORM_IDLE,
        NORM_ROOT,
        NORM_DIV,
        NORM_OUT
    } norm_state_t;

    function automatic logic [`RAY_DIR_W-1:0] magnitude(input ray_pkg::dir_t d);
        magnitude = d[`RAY_DIR_W-1] ? unsigned'(-d) : unsigned'(d);
    endfunction

    norm_state_t        state;
    logic [CNT_W-1:0]   cnt;
    logic [1:0]         idx;
    logic               root_last;
    logic               div_last;

    logic [`RAY_DIR_W-1:0] mag [3];
    logic                  neg [3];
    ray_pkg::unit_t        hold [3];

    ////////////////////////////////////////
    // sum of squares

    logic [`RAY_DIR_W-1:0] in_mag_x;
    logic [`RAY_DIR_W-1:0] in_mag_y;
    logic [`RAY_DIR_W-1:0] in_mag_z;
    ray_pkg::len_sq_t      s_next;

    assign in_mag_x = magnitude(dx);
    assign in_mag_y = magnitude(dy);
    assign in_mag_z = magnitude(dz);
    assign s_next   = SQ_W'(in_mag_x) * SQ_W'(in_mag_x)
                    + SQ_W'(in_mag_y) * SQ_W'(in_mag_y)
                    + SQ_W'(in_mag_z) * SQ_W'(in_mag_z);

    ////////////////////////////////////////
    // square root, two radicand bits per step

    ray_pkg::len_sq_t  sq;
    ray_pkg::len_t     root;
    logic [RT_W-1:0]   rt_rem;
    logic [RT_W-1:0]   rt_sh;
    logic [RT_W-1:0]   rt_trial;
    logic              rt_ge;

    assign rt_sh    = {rt_rem[RT_W-3:0], sq[SQ_W-1 -: 2]};
    assign rt_trial = {1'b0, root, 2'b01};
    assign rt_ge    = (rt_sh >= rt_trial);

    ////////////////////////////////////////
    // restoring divider, quotient shifts in behind the dividend

    logic [DVD_W-1:0]  dv_q;
    logic [DVD_W-1:0]  dv_q_next;
    ray_pkg::len_t     dv_rem;
    logic [LEN_W:0]    dv_sh;
    logic [LEN_W:0]    dv_diff;
    logic              dv_ge;
    ray_pkg::unit_t    dv_mag;
    ray_pkg::unit_t    dv_unit;

    assign dv_sh     = {dv_rem, dv_q[DVD_W-1]};
    assign dv_ge     = (dv_sh >= {1'b0, root});
    assign dv_diff   = dv_sh - {1'b0, root};
    assign dv_q_next = {dv_q[DVD_W-2:0], dv_ge};
    assign dv_mag    = ray_pkg::unit_t'(dv_q_next[UNIT_W-1:0]);
    // zero length gives a zero vector
    assign dv_unit   = (root == '0) ? '0 : (neg[idx] ? -dv_mag : dv_mag);

    assign root_last = (state == NORM_ROOT) && (cnt == CNT_W'(LEN_W - 1));
    assign div_last  = (state == NORM_DIV) && (cnt == CNT_W'(DVD_W - 1));

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state     <= NORM_IDLE;
            cnt       <= '0;
            idx       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                NORM_IDLE: begin
                    if (dir_in_valid) begin
                        state <= NORM_ROOT;
                        cnt   <= '0;
                    end
                end
                NORM_ROOT: begin
                    cnt <= cnt + CNT_W'(1);
                    if (root_last) begin
                        state <= NORM_DIV;
                        cnt   <= '0;
                        idx   <= '0;
                    end
                end
                NORM_DIV: begin
                    cnt <= cnt + CNT_W'(1);
                    if (div_last) begin
                        cnt <= '0;
                        if (idx == 2'd2) begin
                            state <= NORM_OUT;
                        end else begin
                            idx <= idx + 2'd1;
                        end
                    end
                end
                default: begin
                    res_valid <= 1'b1;
                    state     <= NORM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        case (state)
            NORM_IDLE: begin
                if (dir_in_valid) begin
                    mag[0] <= in_mag_x;
                    mag[1] <= in_mag_y;
                    mag[2] <= in_mag_z;
                    neg[0] <= dx[`RAY_DIR_W-1];
                    neg[1] <= dy[`RAY_DIR_W-1];
                    neg[2] <= dz[`RAY_DIR_W-1];
                    sq     <= s_next;
                    rt_rem <= '0;
                    root   <= '0;
                end
            end
            NORM_ROOT: begin
                sq     <= sq << 2;
                root   <= {root[LEN_W-2:0], rt_ge};
                rt_rem <= rt_ge ? (rt_sh - rt_trial) : rt_sh;
                if (root_last) begin
                    dv_q   <= {mag[0], {`RAY_UNIT_FRAC{1'b0}}};
                    dv_rem <= '0;
                end
            end
            NORM_DIV: begin
                dv_q   <= dv_q_next;
                dv_rem <= dv_ge ? dv_diff[LEN_W-1:0] : dv_sh[LEN_W-1:0];
                if (div_last) begin
                    hold[idx] <= dv_unit;
                    // load the next component
                    if (idx != 2'd2) begin
                        dv_q   <= {mag[idx + 2'd1], {`RAY_UNIT_FRAC{1'b0}}};
                        dv_rem <= '0;
                    end
                end
            end
            default: begin
                ux <= hold[0];
                uy <= hold[1];
                uz <= hold[2];
            end
        endcase
    end

endmodule

// File: design/ray_gen_top.sv
`timescale 1ns/100ps
`include "ray_defines.svh"

module ray_gen_top (
    input  logic                    clk_in,
    input  logic                    rst_n,

    input  logic                    cfg_we,
    input  logic [`RAY_ADDR_W-1:0]  cfg_addr,
    input  ray_pkg::cfg_data_t      cfg_wdata,
    input  logic                    frame_start,

    output ray_pkg::pix_x_t         pix_x,
    output ray_pkg::pix_y_t         pix_y,
    output ray_pkg::unit_t          dir_x,
    output ray_pkg::unit_t          dir_y,
    output ray_pkg::unit_t          dir_z,
    output logic                    dir_valid,
    output logic                    frame_done
);

    ray_pkg::coord_t eye_x;
    ray_pkg::coord_t eye_y;
    ray_pkg::coord_t eye_z;
    ray_pkg::coord_t org_x;
    ray_pkg::coord_t org_y;
    ray_pkg::coord_t plane_z;
    ray_pkg::pix_x_t win_w;
    ray_pkg::pix_y_t win_h;

    logic            scan_valid;
    ray_pkg::pix_x_t scan_x;
    ray_pkg::pix_y_t scan_y;
    logic            dir_in_valid;
    ray_pkg::dir_t   dx;
    ray_pkg::dir_t   dy;
    ray_pkg::dir_t   dz;
    logic            res_valid;

    camera_regs u_camera_regs (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .eye_x     (eye_x),
        .eye_y     (eye_y),
        .eye_z     (eye_z),
        .org_x     (org_x),
        .org_y     (org_y),
        .plane_z   (plane_z),
        .win_w     (win_w),
        .win_h     (win_h)
    );

    // next pixel waits for the current result
    pixel_scan u_pixel_scan (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .win_w       (win_w),
        .win_h       (win_h),
        .res_valid   (res_valid),
        .pix_valid   (scan_valid),
        .pix_x       (scan_x),
        .pix_y       (scan_y),
        .frame_done  (frame_done)
    );

    eye_to_pixel u_eye_to_pixel (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .pix_valid    (scan_valid),
        .pix_x        (scan_x),
        .pix_y        (scan_y),
        .eye_x        (eye_x),
        .eye_y        (eye_y),
        .eye_z        (eye_z),
        .org_x        (org_x),
        .org_y        (org_y),
        .plane_z      (plane_z),
        .dir_in_valid (dir_in_valid),
        .dx           (dx),
        .dy           (dy),
        .dz           (dz)
    );

    vec_normalize u_vec_normalize (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .dir_in_valid (dir_in_valid),
        .dx           (dx),
        .dy           (dy),
        .dz           (dz),
        .res_valid    (res_valid),
        .ux           (dir_x),
        .uy           (dir_y),
        .uz           (dir_z)
    );

    assign dir_valid = res_valid;

    // label for the ray in flight, the scanner has moved on by the result
    always_ff @(posedge clk_in) begin
        if (scan_valid) begin
            pix_x <= scan_x;
            pix_y <= scan_y;
        end
    end

endmodule

// File: tests/ray_tb_clock.sv
`timescale 1ns/100ps

// free-running testbench clock, 4 ns period
module ray_tb_clock (
    output logic clk
);

    localparam real HALF_PERIOD = 2.0;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk = ~clk;
        end
    end

endmodule

// File: tests/ray_tb_checks.svh
`ifndef RAY_TB_CHECKS_SVH
`define RAY_TB_CHECKS_SVH

////////////////////////////////////////
// counters

int checks_run  = 0;
int error_count = 0;
int row_errors  = 0;

////////////////////////////////////////
// reference model

// floor square root by binary search
function automatic longint ref_isqrt(input longint s);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    // a 40-bit sum has a root below 2**20
    hi = longint'(1) << 21;
    while (lo < hi) begin
        mid = (lo + hi + 1) / 2;
        if (mid * mid <= s) begin
            lo = mid;
        end else begin
            hi = mid - 1;
        end
    end
    return lo;
endfunction

// Q1.14 component, truncated toward zero
function automatic ray_pkg::unit_t ref_unit(input longint d, input longint len);
    longint q;
    if (len == 0) begin
        return '0;
    end
    q = (d * (longint'(1) << `RAY_UNIT_FRAC)) / len;
    return ray_pkg::unit_t'(q);
endfunction

////////////////////////////////////////
// compare tasks

task automatic flag_error(input string what);
    error_count++;
    row_errors++;
    $display("ERROR %s", what);
endtask

task automatic check_unit(input string name, input ray_pkg::unit_t exp_val,
                          input ray_pkg::unit_t act_val);
    checks_run++;
    if (act_val !== exp_val) begin
        error_count++;
        row_errors++;
        $display("FAIL %s expected %0d actual %0d", name, exp_val, act_val);
    end
endtask

task automatic check_pix(input string name,
                         input ray_pkg::pix_x_t exp_x, input ray_pkg::pix_y_t exp_y,
                         input ray_pkg::pix_x_t act_x, input ray_pkg::pix_y_t act_y);
    checks_run++;
    if (act_x !== exp_x || act_y !== exp_y) begin
        error_count++;
        row_errors++;
        $display("FAIL %s expected (%0d,%0d) actual (%0d,%0d)",
                 name, exp_x, exp_y, act_x, act_y);
    end
endtask

task automatic check_count(input string name, input int exp_val, input int act_val);
    checks_run++;
    if (act_val != exp_val) begin
        error_count++;
        row_errors++;
        $display("FAIL %s expected %0d actual %0d", name, exp_val, act_val);
    end
endtask

`endif

// File: tests/ray_tb.sv
`timescale 1ns/100ps
`include "ray_defines.svh"

module ray_tb;

    localparam int NUM_ROWS   = 7;
    localparam int PIX_CYCLES = `RAY_NORM_CYCLES + 3;

    logic                   clk_in;
    logic                   rst_n;
    logic                   cfg_we;
    logic [`RAY_ADDR_W-1:0] cfg_addr;
    ray_pkg::cfg_data_t     cfg_wdata;
    logic                   frame_start;
    ray_pkg::pix_x_t        pix_x;
    ray_pkg::pix_y_t        pix_y;
    ray_pkg::unit_t         dir_x;
    ray_pkg::unit_t         dir_y;
    ray_pkg::unit_t         dir_z;
    logic                   dir_valid;
    logic                   frame_done;

    `include "ray_tb_checks.svh"

    ////////////////////////////////////////
    // camera table, one frame per row

    string row_name [NUM_ROWS] = '{"ref_cam", "mixed_sign", "zero_len", "one_pixel",
                                   "zero_width", "restart", "after_restart"};
    ray_pkg::coord_t row_eye_x [NUM_ROWS] = '{16'sd1800, 16'sd12, 16'sd100, 16'sd0,
                                             16'sd0, -16'sd1000, 16'sd300};
    ray_pkg::coord_t row_eye_y [NUM_ROWS] = '{16'sd1800, 16'sd22, 16'sd200, 16'sd0,
                                             16'sd0, 16'sd500, -16'sd400};
    ray_pkg::coord_t row_eye_z [NUM_ROWS] = '{-16'sd300, 16'sd0, 16'sd40, 16'sd0,
                                             16'sd0, 16'sd2000, -16'sd20000};
    ray_pkg::coord_t row_org_x [NUM_ROWS] = '{16'sd1544, 16'sd10, 16'sd100, -16'sd500,
                                             16'sd0, -16'sd900, -16'sd2000};
    ray_pkg::coord_t row_org_y [NUM_ROWS] = '{16'sd1608, 16'sd20, 16'sd200, 16'sd300,
                                             16'sd0, 16'sd450, 16'sd1000};
    ray_pkg::coord_t row_plane [NUM_ROWS] = '{16'sd100, 16'sd50, 16'sd40, 16'sd1000,
                                             16'sd10, -16'sd5000, 16'sd20000};
    ray_pkg::pix_x_t row_w [NUM_ROWS] = '{11'd4, 11'd5, 11'd2, 11'd1, 11'd0, 11'd3, 11'd2};
    ray_pkg::pix_y_t row_h [NUM_ROWS] = '{10'd3, 10'd5, 10'd2, 10'd1, 10'd5, 10'd2, 10'd2};
    // stray frame_start in the middle of the frame
    bit row_restart [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    ray_tb_clock u_ray_tb_clock (
        .clk (clk_in)
    );

    ray_gen_top u_ray_gen_top (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .frame_start (frame_start),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .dir_x       (dir_x),
        .dir_y       (dir_y),
        .dir_z       (dir_z),
        .dir_valid   (dir_valid),
        .frame_done  (frame_done)
    );

    // inputs change and outputs are read 1 ns after the edge
    task automatic step();
        @(posedge clk_in);
        #1;
    endtask

    task automatic write_reg(input logic [`RAY_ADDR_W-1:0] addr, input ray_pkg::cfg_data_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
    endtask

    task automatic write_camera(input int r);
        write_reg(`RAY_REG_EYE_X, ray_pkg::cfg_data_t'(row_eye_x[r]));
        write_reg(`RAY_REG_EYE_Y, ray_pkg::cfg_data_t'(row_eye_y[r]));
        write_reg(`RAY_REG_EYE_Z, ray_pkg::cfg_data_t'(row_eye_z[r]));
        write_reg(`RAY_REG_ORG_X, ray_pkg::cfg_data_t'(row_org_x[r]));
        write_reg(`RAY_REG_ORG_Y, ray_pkg::cfg_data_t'(row_org_y[r]));
        write_reg(`RAY_REG_PLANE_Z, ray_pkg::cfg_data_t'(row_plane[r]));
        write_reg(`RAY_REG_WIDTH, ray_pkg::cfg_data_t'(row_w[r]));
        write_reg(`RAY_REG_HEIGHT, ray_pkg::cfg_data_t'(row_h[r]));
        cfg_we = 1'b0;
    endtask

    task automatic check_reset_idle();
        row_errors = 0;
        repeat (10) begin
            checks_run++;
            if (dir_valid !== 1'b0 || frame_done !== 1'b0) begin
                flag_error("dir_valid or frame_done high before the first frame");
            end
            step();
        end
        $display("test reset_idle: %0d errors", row_errors);
    endtask

    task automatic run_frame(input int r);
        int              got;
        int              exp_total;
        logic            done;
        logic            pulsed;
        logic            prev_valid;
        ray_pkg::pix_x_t ex;
        ray_pkg::pix_y_t ey;
        longint          ddx;
        longint          ddy;
        longint          ddz;
        longint          len;
        string           tag;
        got        = 0;
        done       = 1'b0;
        pulsed     = 1'b0;
        prev_valid = 1'b0;
        ex         = '0;
        ey         = '0;
        row_errors = 0;
        exp_total  = int'(row_w[r]) * int'(row_h[r]);
        frame_start = 1'b1;
        step();
        frame_start = 1'b0;
        while (!done) begin
            if (dir_valid) begin
                tag = $sformatf("%s (%0d,%0d)", row_name[r], ex, ey);
                check_pix(tag, ex, ey, pix_x, pix_y);
                ddx = longint'(row_org_x[r]) + longint'(ex) - longint'(row_eye_x[r]);
                ddy = longint'(row_org_y[r]) + longint'(ey) - longint'(row_eye_y[r]);
                ddz = longint'(row_plane[r]) - longint'(row_eye_z[r]);
                len = ref_isqrt(ddx * ddx + ddy * ddy + ddz * ddz);
                check_unit({tag, " x"}, ref_unit(ddx, len), dir_x);
                check_unit({tag, " y"}, ref_unit(ddy, len), dir_y);
                check_unit({tag, " z"}, ref_unit(ddz, len), dir_z);
                got++;
                // row-major order
                if (ex == row_w[r] - ray_pkg::pix_x_t'(1)) begin
                    ex = '0;
                    ey = ey + ray_pkg::pix_y_t'(1);
                end else begin
                    ex = ex + ray_pkg::pix_x_t'(1);
                end
            end
            if (frame_done) begin
                done = 1'b1;
                if (got > 0 && !prev_valid) begin
                    flag_error($sformatf("%s frame_done not one cycle after last result",
                                         row_name[r]));
                end
            end else begin
                frame_start = row_restart[r] && (got == 1) && !pulsed;
                if (frame_start) begin
                    pulsed = 1'b1;
                end
                prev_valid = dir_valid;
                step();
            end
        end
        frame_start = 1'b0;
        check_count({row_name[r], " count"}, exp_total, got);
        $display("test %s: %0d results, %0d errors", row_name[r], got, row_errors);
    endtask

    initial begin
        rst_n       = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        frame_start = 1'b0;
        repeat (2) @(posedge clk_in);
        #1;
        rst_n = 1'b1;
        check_reset_idle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            write_camera(r);
            run_frame(r);
        end
        $display("summary: %0d tests, %0d checks, %0d errors",
                 NUM_ROWS + 1, checks_run, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    ////////////////////////////////////////
    // watchdog

    initial begin
        int limit;
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += 2 * int'(row_w[r]) * int'(row_h[r]) * PIX_CYCLES;
        end
        repeat (limit) @(posedge clk_in);
        $display("watchdog: no end of run after %0d cycles, DUT stopped responding", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
+incdir+tests
design/ray_pkg.sv
design/camera_regs.sv
design/pixel_scan.sv
design/eye_to_pixel.sv
design/vec_normalize.sv
design/ray_gen_top.sv
tests/ray_tb_clock.sv
tests/ray_tb.sv

// File: Makefile
# Verilator build and run for the ray generator testbench

SIM  := obj_dir/Vray_tb
SRCS := $(wildcard design/*.sv design/*.svh tests/*.sv tests/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps --top-module ray_tb \
		-f sources.f -Mdir obj_dir -o Vray_tb

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "Finished with no errors" sim.log; then \
		echo "run passed"; \
	else \
		echo "run failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
